//--- sim.f
+incdir+bench
common/sf_video_pkg.sv
common/sf_cpu_pkg.sv
source/sf_video_timing.sv
source/sf_reg_decode.sv
bg_layer/sf_bg_fetch.sv
bg_layer/sf_bg_pixel.sv
source/sf_bg_top.sv
bench/tb_sf_bg.sv

//--- run_sim.sh
#!/bin/sh
# build the background layer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module tb_sf_bg \
   && ./obj_dir/Vtb_sf_bg | tee /dev/stderr | grep -F -- '*** PASSED ***' > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- bench/sf_bg_ref.svh
// Tile ROM model and reference pixel
`ifndef SF_BG_REF_SVH
`define SF_BG_REF_SVH

localparam logic [31:0] RNG_SEED = 32'h8a7a1075;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s ^ (s << 13);
   x = x ^ (x >> 17);
   return x ^ (x << 5);
endfunction

// each address hashes to its own word, plane 0 in the low byte
function automatic sf_video_pkg::rom_data_t rom_word(input sf_video_pkg::rom_addr_t a);
   logic [31:0] x;
   x = xorshift32(xorshift32(RNG_SEED ^ {19'd0, a}));
   return x[23:0];
endfunction

// row on top, column of the scrolled position below
function automatic sf_video_pkg::rom_addr_t ref_addr(input sf_video_pkg::hpos_t h,
                                                     input sf_cpu_pkg::layer_ctrl_t c);
   int sum;
   sum = (int'(h) + int'(c.scroll)) % 512;
   return {c.row, sf_video_pkg::tile_col_t'(sum / 8)};
endfunction

// ca is the control seen at address time, cp at output time
function automatic sf_video_pkg::pix_t ref_pixel(input sf_video_pkg::hpos_t h,
                                                 input sf_cpu_pkg::layer_ctrl_t ca,
                                                 input sf_cpu_pkg::layer_ctrl_t cp,
                                                 output logic transparent);
   sf_video_pkg::rom_data_t data;
   sf_video_pkg::planes_t   planes;
   sf_video_pkg::pix_t      p;
   int                      fine;
   int                      idx;
   fine = ((int'(h) + int'(ca.scroll)) % 512) % 8;
   idx  = ca.flip ? fine : 7 - fine;
   data = rom_word(ref_addr(h, ca));
   for (int k = 0; k < 3; k++)
      planes[k] = data[8*k + idx];
   p.active    = h < sf_video_pkg::hpos_t'(sf_video_pkg::H_ACTIVE);
   p.hpos      = h;
   transparent = p.active && (planes == '0);
   if (!p.active)
      p.color = '0;
   else if (planes == '0)
      p.color = cp.backdrop;
   else
      p.color = {cp.bank, planes};
   return p;
endfunction

`endif

//--- bench/tb_sf_bg.sv
// Background layer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sf_bg;

   `include "sf_bg_ref.svh"

   localparam int unsigned CLK_PERIOD    = 100;
   localparam int unsigned RESET_CYCLES  = 16;
   localparam int unsigned SCROLL_RUNS   = 10;
   localparam int unsigned FLIP_RUNS     = 4;
   localparam int unsigned LAYER_RUNS    = 4;
   localparam int unsigned UNMAPPED_RUNS = 2;
   localparam int unsigned RUN_LINES     = 2;
   localparam int unsigned ALL_RUNS = SCROLL_RUNS + FLIP_RUNS + LAYER_RUNS + UNMAPPED_RUNS;
   // two zero lines, the runs, and six lines of slack
   localparam int unsigned TIMEOUT_CLKS = (2 + RUN_LINES * ALL_RUNS + 6)
      * sf_video_pkg::H_TOTAL * sf_video_pkg::PIX_DIV + RESET_CYCLES;
   // write window, only blanked positions in flight
   localparam sf_video_pkg::hpos_t WIN_LO = 9'd300;
   localparam sf_video_pkg::hpos_t WIN_HI = 9'd370;
   localparam sf_video_pkg::hpos_t H_LAST = 9'd383;

   logic                      clk;
   logic                      CR;
   logic                      wr_stb;
   sf_cpu_pkg::cpu_wr_t       wr;
   sf_video_pkg::rom_data_t   rom_data;
   sf_video_pkg::rom_addr_t   rom_addr;
   logic                      pix_stb;
   sf_video_pkg::pix_t        pix;

   sf_cpu_pkg::layer_ctrl_t   shadow;
   sf_cpu_pkg::layer_ctrl_t   ctrl_hist [$];
   logic [31:0]               rng_state = RNG_SEED;
   int unsigned               pix_errs = 0;
   int unsigned               addr_errs = 0;
   int unsigned               other_errs = 0;
   int unsigned               strobes = 0;
   int unsigned               transparent_hits = 0;
   int unsigned               clk_count = 0;
   int unsigned               last_stb_clk = 0;
   logic                      have_last = 1'b0;
   sf_video_pkg::hpos_t       last_hpos = '0;

   sf_bg_top uut (
      .clk        (clk),
      .CR         (CR),
      .wr_stb_i   (wr_stb),
      .wr_i       (wr),
      .rom_data_i (rom_data),
      .rom_addr_o (rom_addr),
      .pix_stb_o  (pix_stb),
      .pix_o      (pix)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // tile ROM answers on the falling edge
   initial
   begin
      rom_data = rom_word('0);
      forever
      begin
         @(negedge clk);
         rom_data = rom_word(rom_addr);
      end
   end

   // ============================================================
   // checks and helpers
   // ============================================================
   task automatic compare_pix(input string name, input sf_video_pkg::pix_t got,
                              input sf_video_pkg::pix_t exp);
      if (got !== exp)
      begin
         pix_errs++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic compare_addr(input string name, input sf_video_pkg::rom_addr_t got,
                               input sf_video_pkg::rom_addr_t exp);
      if (got !== exp)
      begin
         addr_errs++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic note_failure(input string msg);
      other_errs++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic print_summary();
      $display("errors: pix_o %0d, rom_addr_o %0d, other %0d (%0d strobes checked)",
               pix_errs, addr_errs, other_errs, strobes);
   endtask

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic sf_video_pkg::hpos_t next_hpos(input sf_video_pkg::hpos_t h,
                                                     input int step);
      return sf_video_pkg::hpos_t'((int'(h) + step) % int'(sf_video_pkg::H_TOTAL));
   endfunction

   // ============================================================
   // compare process
   // ============================================================
   task automatic check_strobe();
      sf_video_pkg::hpos_t       h;
      sf_cpu_pkg::layer_ctrl_t   ctrl_a;
      sf_video_pkg::pix_t        exp_pix;
      logic                      transparent;
      h = have_last ? next_hpos(last_hpos, 1) : '0;
      if (have_last && (clk_count - last_stb_clk != sf_video_pkg::PIX_DIV))
         note_failure($sformatf("pixel strobes %0d clocks apart", clk_count - last_stb_clk));
      // address was formed two dot periods back
      ctrl_hist.push_back(shadow);
      ctrl_a  = ctrl_hist.pop_front();
      exp_pix = ref_pixel(h, ctrl_a, shadow, transparent);
      compare_pix("pix_o", pix, exp_pix);
      compare_addr("rom_addr_o", rom_addr, ref_addr(next_hpos(h, 2), shadow));
      if (transparent && shadow.backdrop != '0)
         transparent_hits++;
      strobes++;
      have_last    = 1'b1;
      last_hpos    = h;
      last_stb_clk = clk_count;
   endtask

   always @(negedge clk)
   begin
      clk_count = clk_count + 1;
      if (!CR && pix_stb)
         note_failure("pixel strobe while reset is held");
      else if (CR && pix_stb)
         check_strobe();
   end

   // ============================================================
   // stimulus
   // ============================================================
   task automatic wait_line_ends(input int unsigned n);
      repeat (n)
      begin
         @(negedge clk);
         while (!(pix_stb && pix.hpos == H_LAST))
            @(negedge clk);
      end
   endtask

   task automatic write_reg(input sf_cpu_pkg::reg_addr_t addr, input logic [7:0] data);
      @(negedge clk);
      while (!(pix_stb && pix.hpos >= WIN_LO && pix.hpos <= WIN_HI))
         @(negedge clk);
      wr_stb  = 1'b1;
      wr.addr = addr;
      wr.data = data;
      @(posedge clk);
      // register map as seen by the CPU
      case (addr)
         sf_cpu_pkg::REG_SCROLL_LO: shadow.scroll[7:0] = data;
         sf_cpu_pkg::REG_SCROLL_HI:
         begin
            shadow.scroll[8] = data[0];
            shadow.flip      = data[1];
         end
         sf_cpu_pkg::REG_ROW:       shadow.row = data[6:0];
         sf_cpu_pkg::REG_BANK:      shadow.bank = data[1:0];
         sf_cpu_pkg::REG_BACKDROP:  shadow.backdrop = data[4:0];
         default: ;
      endcase
      @(negedge clk);
      wr_stb = 1'b0;
      wr     = '0;
   endtask

   task automatic set_scroll(input sf_video_pkg::scroll_t s, input logic flip);
      write_reg(sf_cpu_pkg::REG_SCROLL_LO, s[7:0]);
      write_reg(sf_cpu_pkg::REG_SCROLL_HI, {6'd0, flip, s[8]});
   endtask

   initial
   begin
      sf_video_pkg::scroll_t s;
      logic [31:0]           r;
      CR     = 1'b0;
      wr_stb = 1'b0;
      wr     = '0;
      shadow = '0;
      ctrl_hist.push_back(shadow);
      ctrl_hist.push_back(shadow);
      repeat (RESET_CYCLES) @(negedge clk);
      compare_pix("pix_o", pix, '0);
      compare_addr("rom_addr_o", rom_addr, '0);
      CR = 1'b1;
      wait_line_ends(2);
      for (int i = 0; i < SCROLL_RUNS; i++)
      begin
         r = next_rand();
         // wrap corner values first
         s = (i == 0) ? 9'h1ff : (i == 1) ? 9'h100 : r[8:0];
         set_scroll(s, 1'b0);
         wait_line_ends(RUN_LINES);
      end
      for (int i = 0; i < FLIP_RUNS; i++)
      begin
         r = next_rand();
         set_scroll(r[8:0], 1'b1);
         wait_line_ends(RUN_LINES);
      end
      for (int i = 0; i < LAYER_RUNS; i++)
      begin
         r = next_rand();
         set_scroll(r[8:0], r[9]);
         write_reg(sf_cpu_pkg::REG_ROW, r[17:10]);
         write_reg(sf_cpu_pkg::REG_BANK, r[25:18]);
         write_reg(sf_cpu_pkg::REG_BACKDROP, r[31:24] | 8'h01);
         wait_line_ends(RUN_LINES);
      end
      for (int i = 0; i < UNMAPPED_RUNS; i++)
      begin
         for (int a = 5; a < 8; a++)
         begin
            r = next_rand();
            write_reg(sf_cpu_pkg::reg_addr_t'(a), r[7:0]);
         end
         wait_line_ends(RUN_LINES);
      end
      if (transparent_hits == 0)
         note_failure("no transparent pixel showed a nonzero backdrop");
      print_summary();
      if (pix_errs + addr_errs + other_errs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (TIMEOUT_CLKS) @(posedge clk);
      note_failure("timeout, the tests did not finish in time");
      print_summary();
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/sf_bg_top.sv
// Scrolling background layer top
`timescale 1ns/1ps
`default_nettype none

module sf_bg_top
(
   input  wire                      clk,
   input  wire                      CR,
   input  logic                     wr_stb_i,
   input  sf_cpu_pkg::cpu_wr_t      wr_i,
   input  sf_video_pkg::rom_data_t  rom_data_i,
   output sf_video_pkg::rom_addr_t  rom_addr_o,
   output logic                     pix_stb_o,
   output sf_video_pkg::pix_t       pix_o
);

   logic                      pix_en;
   sf_video_pkg::hpos_t       hpos;
   sf_cpu_pkg::layer_ctrl_t   ctrl;
   logic                      fetch_vld;
   sf_video_pkg::fetch_t      fetch;

   // ============================================================
   // timing and registers
   // ============================================================
   sf_video_timing u_timing (
      .clk      (clk),
      .CR       (CR),
      .pix_en_o (pix_en),
      .hpos_o   (hpos)
   );

   sf_reg_decode u_regs (
      .clk      (clk),
      .CR       (CR),
      .wr_stb_i (wr_stb_i),
      .wr_i     (wr_i),
      .ctrl_o   (ctrl)
   );

   // ============================================================
   // layer pipeline
   // ============================================================
   sf_bg_fetch u_fetch (
      .clk         (clk),
      .CR          (CR),
      .pix_en_i    (pix_en),
      .hpos_i      (hpos),
      .ctrl_i      (ctrl),
      .rom_data_i  (rom_data_i),
      .rom_addr_o  (rom_addr_o),
      .fetch_vld_o (fetch_vld),
      .fetch_o     (fetch)
   );

   sf_bg_pixel u_pixel (
      .clk         (clk),
      .CR          (CR),
      .fetch_vld_i (fetch_vld),
      .fetch_i     (fetch),
      .ctrl_i      (ctrl),
      .pix_stb_o   (pix_stb_o),
      .pix_o       (pix_o)
   );

endmodule

`default_nettype wire

//--- bg_layer/sf_bg_pixel.sv
// Background colour stage
`timescale 1ns/1ps
`default_nettype none

module sf_bg_pixel
(
   input  wire                      clk,
   input  wire                      CR,
   input  logic                     fetch_vld_i,
   input  sf_video_pkg::fetch_t     fetch_i,
   input  sf_cpu_pkg::layer_ctrl_t  ctrl_i,
   output logic                     pix_stb_o,
   output sf_video_pkg::pix_t       pix_o
);

   // ============================================================
   // colour select
   // ============================================================
   sf_video_pkg::color_t color_nxt;

   always_comb
   begin
      if (!fetch_i.active)
         // blanking
         color_nxt = '0;
      else if (fetch_i.planes == '0)
         // transparent, show backdrop
         color_nxt = ctrl_i.backdrop;
      else
         color_nxt = {ctrl_i.bank, fetch_i.planes};
   end

   // ============================================================
   // output register
   // ============================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pix_stb_o <= 1'b0;
         pix_o     <= '0;
      end
      else
      begin
         pix_stb_o <= fetch_vld_i;
         if (fetch_vld_i)
         begin
            pix_o.active <= fetch_i.active;
            pix_o.hpos   <= fetch_i.hpos;
            pix_o.color  <= color_nxt;
         end
      end
   end

   // strobe is a single clock wide
   a_stb_single : assert property (
      @(posedge clk) disable iff (!CR)
      pix_stb_o |=> !pix_stb_o
   ) else $error("pixel strobe high on two consecutive clocks");

endmodule

`default_nettype wire

//--- bg_layer/sf_bg_fetch.sv
// Background tile fetch and bitplane select
`timescale 1ns/1ps
`default_nettype none

module sf_bg_fetch
(
   input  wire                      clk,
   input  wire                      CR,
   input  logic                     pix_en_i,
   input  sf_video_pkg::hpos_t      hpos_i,
   input  sf_cpu_pkg::layer_ctrl_t  ctrl_i,
   input  sf_video_pkg::rom_data_t  rom_data_i,
   output sf_video_pkg::rom_addr_t  rom_addr_o,
   output logic                     fetch_vld_o,
   output sf_video_pkg::fetch_t     fetch_o
);

   // ============================================================
   // scroll adder
   // ============================================================
   // nibble chain like the two 74283s plus a top bit
   logic [3:0]                sum_lo;
   logic [3:0]                sum_mid;
   logic                      c4_lo;
   logic                      c4_mid;
   sf_video_pkg::scroll_t     sum;
   sf_video_pkg::tile_col_t   col;
   sf_video_pkg::fine_t       fine;

   always_comb
   begin
      {c4_lo, sum_lo}   = {1'b0, hpos_i[3:0]} + {1'b0, ctrl_i.scroll[3:0]};
      {c4_mid, sum_mid} = {1'b0, hpos_i[7:4]} + {1'b0, ctrl_i.scroll[7:4]} + {4'd0, c4_lo};
      // carry out of bit 8 dropped, so the sum wraps at 512
      sum  = {hpos_i[8] ^ ctrl_i.scroll[8] ^ c4_mid, sum_mid, sum_lo};
      col  = sum[8:3];
      fine = sum[2:0];
   end

   // ============================================================
   // stage A: ROM address
   // ============================================================
   logic                  a_vld;
   logic                  a_active;
   logic                  a_flip;
   sf_video_pkg::hpos_t   a_hpos;
   sf_video_pkg::fine_t   a_fine;

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         a_vld      <= 1'b0;
         rom_addr_o <= '0;
      end
      else if (pix_en_i)
      begin
         a_vld      <= 1'b1;
         rom_addr_o <= {ctrl_i.row, col};
      end
   end

   always_ff @(posedge clk)
   begin
      if (pix_en_i)
      begin
         a_hpos   <= hpos_i;
         a_fine   <= fine;
         a_flip   <= ctrl_i.flip;
         a_active <= hpos_i < sf_video_pkg::hpos_t'(sf_video_pkg::H_ACTIVE);
      end
   end

   // ============================================================
   // stage B: bit select
   // ============================================================
   sf_video_pkg::fine_t     bit_sel;
   sf_video_pkg::planes_t   planes_sel;
   logic                    b_vld;
   sf_video_pkg::fetch_t    b_fetch;

   always_comb
   begin
      // msb first normally, lsb first when flipped
      bit_sel = a_flip ? a_fine : ~a_fine;
      for (int p = 0; p < sf_video_pkg::NUM_PLANES; p++)
      begin
         planes_sel[p] = rom_data_i[sf_video_pkg::PLANE_W*p + int'(bit_sel)];
      end
   end

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         b_vld <= 1'b0;
      else if (pix_en_i)
         b_vld <= a_vld;
   end

   always_ff @(posedge clk)
   begin
      if (pix_en_i)
      begin
         b_fetch.active <= a_active;
         b_fetch.hpos   <= a_hpos;
         b_fetch.planes <= planes_sel;
      end
   end

   // handed over on the next enable
   assign fetch_vld_o = pix_en_i & b_vld;
   assign fetch_o     = b_fetch;

   // stage B was loaded exactly one dot period earlier
   a_vld_after_en : assert property (
      @(posedge clk) disable iff (!CR)
      fetch_vld_o |-> $past(pix_en_i, sf_video_pkg::PIX_DIV)
   ) else $error("fetch valid without an enable one dot earlier");

endmodule

`default_nettype wire

//--- source/sf_reg_decode.sv
// CPU register decode for the background layer
`timescale 1ns/1ps
`default_nettype none

module sf_reg_decode
(
   input  wire                      clk,
   input  wire                      CR,
   input  logic                     wr_stb_i,
   input  sf_cpu_pkg::cpu_wr_t      wr_i,
   output sf_cpu_pkg::layer_ctrl_t  ctrl_o
);

   // ============================================================
   // address decode
   // ============================================================
   // active low selects, enabled by the write strobe
   logic [sf_cpu_pkg::REG_SLOTS-1:0] sel_n;

   always_comb
   begin
      for (int i = 0; i < sf_cpu_pkg::REG_SLOTS; i++)
      begin
         sel_n[i] = !(wr_stb_i && (wr_i.addr == sf_cpu_pkg::reg_addr_t'(i)));
      end
   end

   // ============================================================
   // control registers
   // ============================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         ctrl_o <= '0;
      else
      begin
         if (!sel_n[sf_cpu_pkg::REG_SCROLL_LO])
            ctrl_o.scroll[7:0] <= wr_i.data;

         // scroll msb and flip share one byte
         if (!sel_n[sf_cpu_pkg::REG_SCROLL_HI])
         begin
            ctrl_o.scroll[8] <= wr_i.data[0];
            ctrl_o.flip      <= wr_i.data[1];
         end

         if (!sel_n[sf_cpu_pkg::REG_ROW])
            ctrl_o.row <= wr_i.data[sf_video_pkg::TILE_ROW_W-1:0];

         if (!sel_n[sf_cpu_pkg::REG_BANK])
            ctrl_o.bank <= wr_i.data[1:0];

         if (!sel_n[sf_cpu_pkg::REG_BACKDROP])
            ctrl_o.backdrop <= wr_i.data[4:0];

         // selects 5 to 7 go nowhere
      end
   end

   // no two registers ever written in the same cycle
   a_sel_onehot : assert property (
      @(posedge clk) disable iff (!CR)
      $onehot0(~sel_n)
   ) else $error("more than one register select active: %b", sel_n);

endmodule

`default_nettype wire

//--- source/sf_video_timing.sv
// Dot clock enable and horizontal counter
`timescale 1ns/1ps
`default_nettype none

module sf_video_timing
(
   input  wire                  clk,
   input  wire                  CR,
   output logic                 pix_en_o,
   output sf_video_pkg::hpos_t  hpos_o
);

   // ============================================================
   // dot clock enable
   // ============================================================
   logic [2:0] div_q;
   logic       div_b2_q;

   // free running divide by 8, enable on the rise of bit 2
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_q    <= '0;
         div_b2_q <= 1'b0;
         pix_en_o <= 1'b0;
      end
      else
      begin
         div_q    <= div_q + 3'd1;
         div_b2_q <= div_q[2];
         pix_en_o <= div_q[2] & ~div_b2_q;
      end
   end

   // ============================================================
   // horizontal counter
   // ============================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         hpos_o <= '0;
      else if (pix_en_o)
      begin
         // wrap at the end of the line
         if (hpos_o == sf_video_pkg::hpos_t'(sf_video_pkg::H_TOTAL - 1))
            hpos_o <= '0;
         else
            hpos_o <= hpos_o + sf_video_pkg::hpos_t'(1);
      end
   end

   // counter never leaves the line
   a_hpos_range : assert property (
      @(posedge clk) disable iff (!CR)
      hpos_o < sf_video_pkg::hpos_t'(sf_video_pkg::H_TOTAL)
   ) else $error("hpos out of range: %0d", hpos_o);

endmodule

`default_nettype wire

//--- common/sf_cpu_pkg.sv
// CPU register map for the background layer
`default_nettype none

package sf_cpu_pkg;

   typedef logic [2:0] reg_addr_t;

   // one select line per address, as on the 74138
   localparam int unsigned REG_SLOTS = 8;

   // ============================================================
   // register map
   // ============================================================
   // scroll bits 7:0
   localparam reg_addr_t REG_SCROLL_LO = 3'd0;
   // bit 0 is scroll bit 8, bit 1 is flip
   localparam reg_addr_t REG_SCROLL_HI = 3'd1;
   localparam reg_addr_t REG_ROW       = 3'd2;
   localparam reg_addr_t REG_BANK      = 3'd3;
   localparam reg_addr_t REG_BACKDROP  = 3'd4;
   // addresses 5 to 7 are not decoded to anything

   typedef struct packed {
      reg_addr_t  addr;
      logic [7:0] data;
   } cpu_wr_t;

   typedef struct packed {
      sf_video_pkg::scroll_t                    scroll;
      logic                                     flip;
      logic [sf_video_pkg::TILE_ROW_W-1:0]      row;
      logic [1:0]                               bank;
      sf_video_pkg::color_t                     backdrop;
   } layer_ctrl_t;

endpackage

`default_nettype wire

//--- common/sf_video_pkg.sv
// Background layer video types
`default_nettype none

package sf_video_pkg;

   // ============================================================
   // pixel timing
   // ============================================================
   // 48 MHz / 8 = 6 MHz dot clock
   localparam int unsigned PIX_DIV  = 8;
   localparam int unsigned H_TOTAL  = 384;
   localparam int unsigned H_ACTIVE = 256;

   // ============================================================
   // tile ROM geometry
   // ============================================================
   localparam int unsigned NUM_PLANES = 3;
   localparam int unsigned PLANE_W    = 8;
   localparam int unsigned TILE_ROW_W = 7;
   localparam int unsigned TILE_COL_W = 6;

   typedef logic [8:0] hpos_t;
   typedef logic [8:0] scroll_t;
   typedef logic [TILE_COL_W-1:0] tile_col_t;
   typedef logic [2:0] fine_t;
   typedef logic [NUM_PLANES-1:0] planes_t;
   typedef logic [4:0] color_t;

   // row in the upper bits, column below
   typedef logic [TILE_ROW_W+TILE_COL_W-1:0] rom_addr_t;
   // plane 0 sits in the low byte
   typedef logic [NUM_PLANES*PLANE_W-1:0] rom_data_t;

   // fetch to pixel stage
   typedef struct packed {
      logic    active;
      hpos_t   hpos;
      planes_t planes;
   } fetch_t;

   // layer output pixel
   typedef struct packed {
      logic   active;
      hpos_t  hpos;
      color_t color;
   } pix_t;

endpackage

`default_nettype wire
